//--- test/lsuGolden.txt
// Columns: command (1 load, 2 store, 3 amo), size (0 b, 1 h, 2 w, 3 bu, 4 hu), amo op,
// address, store value, expected result (old word for an amo, unused for a store)
1 0 0 0003 00000000 FFFFFFA6
1 3 0 0003 00000000 000000A6
1 1 0 0012 00000000 FFFFB6B7
1 4 0 0012 00000000 0000B6B7
1 2 0 0024 00000000 82838081
1 0 0 00A7 00000000 00000002
2 0 0 0041 11223344 00000000
2 0 0 0043 000000C3 00000000
1 2 0 0040 00000000 C3E744E5
2 1 0 0044 12345678 00000000
1 2 0 0044 00000000 E2E35678
2 0 0 004A 00000077 00000000
1 2 0 0048 00000000 EE77ECED
2 2 0 004C CAFEF00D 00000000
2 1 0 004E 00001234 00000000
1 2 0 004C 00000000 1234F00D
3 2 0 0080 80000001 26272425
3 2 1 0080 7FFFFFFF 80000001
3 2 2 0080 0F0F00FF 00000000
3 2 3 0080 FF00FF0F 0F0F00FF
3 2 4 0080 10203040 0F00000F
3 2 5 0080 FFFFFFF0 1F20304F
3 2 6 0080 00000005 FFFFFFF0
3 2 7 0080 FFFFFFFE 00000005
3 2 8 0080 80000000 00000005
1 2 0 0080 00000000 80000000
2 2 0 0100 DEADBEEF 00000000
1 2 0 1100 00000000 B7B6B5B4
1 2 0 0100 00000000 DEADBEEF
1 2 0 2080 00000000 06070405
1 2 0 0080 00000000 80000000

//--- flist.f
source/lsuPkg.sv
source/accessDataPath.sv
source/cacheArrays.sv
source/lineReplacer.sv
source/lsuControl.sv
source/loadStoreUnit.sv
test/memoryModel.sv
test/lsuTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert
TOP = lsuTb
FILELIST = flist.f
BUILD_DIR = obj_dir
LOG = sim.log
PASS_TEXT = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -x "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/lsuTb.sv
`default_nettype none

module lsuTb;
    localparam int addrWidth = 16;
    localparam int lineBytes = 16;
    localparam int indexWidth = 4;
    localparam int offsetWidth = $clog2(lineBytes);
    localparam int lineAddrWidth = addrWidth - offsetWidth;
    localparam int lineWidth = lineBytes * 8;
    localparam int lineCount = 1 << indexWidth;
    localparam int clockPeriod = 20;
    localparam int resetCycles = 3;
    localparam int driveDelay = 2;
    localparam int cyclesPerRecord = 200;
    localparam int fieldCount = 6;
    localparam int maxRecords = 64;
    // Acceptance cycle plus the lookup cycle
    localparam int hitCycles = 2;

    logic clk;
    logic rst;
    logic enable;
    lsuPkg::lsuCommand command;
    lsuPkg::accessSize size;
    lsuPkg::atomicOp atomicType;
    logic [addrWidth-1:0] addr;
    lsuPkg::word storeValue;
    logic done;
    lsuPkg::word result;
    logic [lineAddrWidth-1:0] memAddr;
    logic memReadReq;
    logic memWriteReq;
    logic [lineWidth-1:0] memWriteValue;
    logic memReadGrant;
    logic [lineWidth-1:0] memReadValue;
    logic memWriteGrant;

    logic [31:0] golden [maxRecords * fieldCount];
    logic [lineAddrWidth-1:0] residentLine [lineCount];
    logic residentValid [lineCount];
    int recordCount;
    bit goldenLoaded;
    int mismatchCount;
    int otherCount;
    int enableErrors;

    loadStoreUnit #(
        .addrWidth(addrWidth),
        .lineBytes(lineBytes),
        .indexWidth(indexWidth)
    ) u_dut (
        .clk,
        .rst,
        .enable,
        .command,
        .size,
        .atomicType,
        .addr,
        .storeValue,
        .done,
        .result,
        .memAddr,
        .memReadReq,
        .memWriteReq,
        .memWriteValue,
        .memReadGrant,
        .memReadValue,
        .memWriteGrant
    );

    memoryModel #(
        .addrWidth(addrWidth),
        .lineBytes(lineBytes)
    ) u_memory (
        .clk,
        .rst,
        .memAddr,
        .memReadReq,
        .memWriteReq,
        .memWriteValue,
        .memReadGrant,
        .memReadValue,
        .memWriteGrant
    );

    initial begin
        clk = 1'b0;
        forever #(clockPeriod / 2) clk = ~clk;
    end

    // Outputs are sampled mid-cycle, away from both edges
    always @(negedge clk) begin
        if (!rst && done && !enable) begin
            $display("done went high at time %0t while enable was low", $time);
            enableErrors++;
        end
    end

    task automatic runCommand(input int record);
        int base;
        int cycles;
        logic [indexWidth-1:0] index;
        logic wasResident;
        lsuPkg::word expected;
        base = record * fieldCount;
        command = lsuPkg::lsuCommand'(golden[base][1:0]);
        size = lsuPkg::accessSize'(golden[base + 1][2:0]);
        atomicType = lsuPkg::atomicOp'(golden[base + 2][3:0]);
        addr = golden[base + 3][addrWidth-1:0];
        storeValue = golden[base + 4];
        expected = golden[base + 5];
        index = addr[offsetWidth +: indexWidth];
        wasResident = residentValid[index] && residentLine[index] == addr[addrWidth-1:offsetWidth];
        enable = 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!done);
        if (command != lsuPkg::CmdStore && result != expected) begin
            $display("mismatch at time %0t: record %0d at %h returned %h, expected %h",
                     $time, record, addr, result, expected);
            mismatchCount++;
        end
        if (command == lsuPkg::CmdLoad && wasResident && cycles != hitCycles) begin
            $display("mismatch at time %0t: hit at %h took %0d cycles, expected %0d",
                     $time, addr, cycles, hitCycles);
            mismatchCount++;
        end
        // Write-allocate leaves every accessed line resident
        residentValid[index] = 1'b1;
        residentLine[index] = addr[addrWidth-1:offsetWidth];
        @(posedge clk);
        #(driveDelay);
        enable = 1'b0;
        command = lsuPkg::CmdNone;
        @(posedge clk);
        #(driveDelay);
    endtask

    initial begin
        int r;
        rst = 1'b1;
        enable = 1'b0;
        command = lsuPkg::CmdNone;
        size = lsuPkg::SizeWord;
        atomicType = lsuPkg::AmoSwap;
        addr = '0;
        storeValue = '0;
        mismatchCount = 0;
        otherCount = 0;
        for (r = 0; r < maxRecords * fieldCount; r++) begin
            golden[r] = '1;
        end
        for (r = 0; r < lineCount; r++) begin
            residentValid[r] = 1'b0;
            residentLine[r] = '0;
        end
        $readmemh("test/lsuGolden.txt", golden);
        recordCount = 0;
        while (recordCount < maxRecords && golden[recordCount * fieldCount] != '1) begin
            recordCount++;
        end
        goldenLoaded = 1'b1;
        if (recordCount == 0) begin
            $display("the golden file holds no commands");
            otherCount++;
        end
        repeat (resetCycles) @(posedge clk);
        #(driveDelay);
        rst = 1'b0;
        for (r = 0; r < recordCount; r++) begin
            runCommand(r);
        end
        repeat (4) @(posedge clk);
        $display("Summary: %0d commands, %0d mismatches, %0d done without enable, %0d other",
                 recordCount, mismatchCount, enableErrors, otherCount);
        if (mismatchCount == 0 && enableErrors == 0 && otherCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        int limitCycles;
        wait (goldenLoaded);
        limitCycles = (recordCount + 1) * cyclesPerRecord;
        #(limitCycles * clockPeriod);
        $display("watchdog expired after %0d cycles before all commands finished", limitCycles);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/memoryModel.sv
`default_nettype none

module memoryModel #(
    parameter int addrWidth = 16,
    parameter int lineBytes = 16,
    localparam int offsetWidth = $clog2(lineBytes),
    localparam int lineAddrWidth = addrWidth - offsetWidth,
    localparam int lineWidth = lineBytes * 8
) (
    input  logic clk,
    input  logic rst,
    input  logic [lineAddrWidth-1:0] memAddr,
    input  logic memReadReq,
    input  logic memWriteReq,
    input  logic [lineWidth-1:0] memWriteValue,
    output logic memReadGrant,
    output logic [lineWidth-1:0] memReadValue,
    output logic memWriteGrant
);
    localparam int lineCount = 1 << lineAddrWidth;

    logic [lineWidth-1:0] lines [lineCount];
    logic [15:0] lfsr = 16'd24311;
    logic pending = 1'b0;
    logic [1:0] waitCycles = 2'd0;
    logic readGrantReg = 1'b0;
    logic writeGrantReg = 1'b0;
    logic [lineWidth-1:0] readData = '0;

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsrStep(input logic [15:0] current);
        return {current[14:0], current[15] ^ current[13] ^ current[12] ^ current[10]};
    endfunction

    // Both address bytes enter the pattern so lines sharing an index differ
    initial begin
        logic [15:0] byteAddr;
        for (int l = 0; l < lineCount; l++) begin
            for (int b = 0; b < lineBytes; b++) begin
                byteAddr = 16'(l * lineBytes + b);
                lines[l][b*8 +: 8] = byteAddr[7:0] ^ byteAddr[15:8] ^ 8'hA5;
            end
        end
    end

    // Two LFSR bits pick a grant delay of 0 to 3 cycles per request
    always @(posedge clk) begin : grantLogic
        logic [15:0] firstStep;
        logic [15:0] secondStep;
        if (rst) begin
            lfsr <= 16'd24311;
            pending <= 1'b0;
            readGrantReg <= 1'b0;
            writeGrantReg <= 1'b0;
        end else if (readGrantReg || writeGrantReg) begin
            readGrantReg <= 1'b0;
            writeGrantReg <= 1'b0;
        end else if (memReadReq || memWriteReq) begin
            if (!pending) begin
                firstStep = lfsrStep(lfsr);
                secondStep = lfsrStep(firstStep);
                lfsr <= secondStep;
                waitCycles <= {firstStep[0], secondStep[0]};
                pending <= 1'b1;
            end else if (waitCycles != 2'd0) begin
                waitCycles <= waitCycles - 2'd1;
            end else if (memReadReq) begin
                pending <= 1'b0;
                readGrantReg <= 1'b1;
                readData <= lines[memAddr];
            end else begin
                pending <= 1'b0;
                writeGrantReg <= 1'b1;
                lines[memAddr] <= memWriteValue;
            end
        end
    end

    assign memReadGrant = readGrantReg;
    assign memWriteGrant = writeGrantReg;
    assign memReadValue = readData;

endmodule

`default_nettype wire

//--- source/loadStoreUnit.sv
`default_nettype none

module loadStoreUnit #(
    parameter int addrWidth = 16,
    parameter int lineBytes = 16,
    parameter int indexWidth = 4,
    localparam int offsetWidth = $clog2(lineBytes),
    localparam int tagWidth = addrWidth - indexWidth - offsetWidth,
    localparam int lineWidth = lineBytes * 8
) (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    input  lsuPkg::lsuCommand command,
    input  lsuPkg::accessSize size,
    input  lsuPkg::atomicOp atomicType,
    input  logic [addrWidth-1:0] addr,
    input  lsuPkg::word storeValue,
    output logic done,
    output lsuPkg::word result,
    output logic [addrWidth-offsetWidth-1:0] memAddr,
    output logic memReadReq,
    output logic memWriteReq,
    output logic [lineWidth-1:0] memWriteValue,
    input  logic memReadGrant,
    input  logic [lineWidth-1:0] memReadValue,
    input  logic memWriteGrant
);
    logic tagReadValid;
    logic [tagWidth-1:0] tagRead;
    logic [lineWidth-1:0] dataReadLine;
    logic [indexWidth-1:0] arrayIndex;
    logic tagWrite;
    logic tagWriteValid;
    logic [tagWidth-1:0] tagWriteValue;
    logic [lineWidth-1:0] dataWriteLine;
    logic [lineBytes-1:0] dataWriteMask;

    lsuPkg::cacheCommand replacerCommand;
    logic [addrWidth-offsetWidth-1:0] lineAddr;
    logic replacerDone;
    logic refillWrite;
    logic [indexWidth-1:0] refillIndex;
    logic [tagWidth-1:0] refillTag;
    logic [lineWidth-1:0] refillData;

    lsuPkg::accessSize regSize;
    logic [offsetWidth-1:0] regOffset;
    lsuPkg::word regStoreValue;
    lsuPkg::word loadResult;
    lsuPkg::word atomicResult;
    logic [lineWidth-1:0] storeLine;
    logic [lineBytes-1:0] writeMask;

    lsuControl #(
        .addrWidth(addrWidth),
        .lineBytes(lineBytes),
        .indexWidth(indexWidth)
    ) u_control (
        .clk,
        .rst,
        .enable,
        .command,
        .atomicType,
        .size,
        .addr,
        .storeValue,
        .tagReadValid,
        .tagRead,
        .replacerDone,
        .loadResult,
        .atomicResult,
        .storeLine,
        .writeMask,
        .refillWrite,
        .refillIndex,
        .refillTag,
        .refillData,
        .done,
        .result,
        .arrayIndex,
        .tagWrite,
        .tagWriteValid,
        .tagWriteValue,
        .dataWriteLine,
        .dataWriteMask,
        .replacerCommand,
        .lineAddr,
        .regSize,
        .regOffset,
        .regStoreValue
    );

    cacheArrays #(
        .addrWidth(addrWidth),
        .lineBytes(lineBytes),
        .indexWidth(indexWidth)
    ) u_arrays (
        .clk,
        .rst,
        .index(arrayIndex),
        .tagWrite,
        .tagWriteValid,
        .tagWriteValue,
        .dataWriteLine,
        .dataWriteMask,
        .tagReadValid,
        .tagRead,
        .dataReadLine
    );

    lineReplacer #(
        .addrWidth(addrWidth),
        .lineBytes(lineBytes),
        .indexWidth(indexWidth)
    ) u_replacer (
        .clk,
        .rst,
        .replacerCommand,
        .lineAddr,
        .dataReadLine,
        .memReadGrant,
        .memReadValue,
        .memWriteGrant,
        .memAddr,
        .memReadReq,
        .memWriteReq,
        .memWriteValue,
        .refillWrite,
        .refillIndex,
        .refillTag,
        .refillData,
        .replacerDone
    );

    // Old word for the ALU is the load result of the AMO's lookup cycle
    accessDataPath #(
        .lineBytes(lineBytes)
    ) u_dataPath (
        .regSize,
        .regOffset,
        .atomicType,
        .regStoreValue,
        .dataReadLine,
        .oldValue(loadResult),
        .loadResult,
        .storeLine,
        .writeMask,
        .atomicResult
    );

endmodule

`default_nettype wire

//--- source/lsuControl.sv
`default_nettype none

module lsuControl #(
    parameter int addrWidth = 16,
    parameter int lineBytes = 16,
    parameter int indexWidth = 4,
    localparam int offsetWidth = $clog2(lineBytes),
    localparam int tagWidth = addrWidth - indexWidth - offsetWidth,
    localparam int lineWidth = lineBytes * 8
) (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    input  lsuPkg::lsuCommand command,
    input  lsuPkg::atomicOp atomicType,
    input  lsuPkg::accessSize size,
    input  logic [addrWidth-1:0] addr,
    input  lsuPkg::word storeValue,
    input  logic tagReadValid,
    input  logic [tagWidth-1:0] tagRead,
    input  logic replacerDone,
    input  lsuPkg::word loadResult,
    input  lsuPkg::word atomicResult,
    input  logic [lineWidth-1:0] storeLine,
    input  logic [lineBytes-1:0] writeMask,
    input  logic refillWrite,
    input  logic [indexWidth-1:0] refillIndex,
    input  logic [tagWidth-1:0] refillTag,
    input  logic [lineWidth-1:0] refillData,
    output logic done,
    output lsuPkg::word result,
    output logic [indexWidth-1:0] arrayIndex,
    output logic tagWrite,
    output logic tagWriteValid,
    output logic [tagWidth-1:0] tagWriteValue,
    output logic [lineWidth-1:0] dataWriteLine,
    output logic [lineBytes-1:0] dataWriteMask,
    output lsuPkg::cacheCommand replacerCommand,
    output logic [addrWidth-offsetWidth-1:0] lineAddr,
    output lsuPkg::accessSize regSize,
    output logic [offsetWidth-1:0] regOffset,
    output lsuPkg::word regStoreValue
);
    lsuPkg::lsuState state;
    lsuPkg::lsuState nextState;
    logic [addrWidth-1:0] regAddr;
    lsuPkg::word oldValue;
    logic lookupValid;
    logic miss;

    always_comb begin
        miss = lookupValid && (!tagReadValid || tagRead != regAddr[addrWidth-1 -: tagWidth]);
        lineAddr = regAddr[addrWidth-1:offsetWidth];
        regOffset = regAddr[offsetWidth-1:0];
        done = (state == lsuPkg::StateLoad && !miss && command == lsuPkg::CmdLoad) ||
               (state == lsuPkg::StateWriteThrough && replacerDone);
        result = (command == lsuPkg::CmdAtomicMemOp) ? oldValue : loadResult;
    end

    always_comb begin
        nextState = state;
        case (state)
            lsuPkg::StateIdle: begin
                if (enable && command == lsuPkg::CmdStore) begin
                    nextState = lsuPkg::StateStore;
                end else if (enable && command != lsuPkg::CmdNone) begin
                    nextState = lsuPkg::StateLoad;
                end
            end
            lsuPkg::StateLoad: begin
                if (miss) begin
                    nextState = lsuPkg::StateRefill;
                end else if (command == lsuPkg::CmdAtomicMemOp) begin
                    nextState = lsuPkg::StateStore;
                end else begin
                    nextState = lsuPkg::StateIdle;
                end
            end
            lsuPkg::StateStore: begin
                nextState = miss ? lsuPkg::StateRefill : lsuPkg::StateWriteThrough;
            end
            // A refilled command starts over from idle
            lsuPkg::StateRefill, lsuPkg::StateWriteThrough: begin
                if (replacerDone) begin
                    nextState = lsuPkg::StateIdle;
                end
            end
            default: nextState = lsuPkg::StateIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= lsuPkg::StateIdle;
            lookupValid <= 1'b0;
        end else begin
            state <= nextState;
            lookupValid <= (state == lsuPkg::StateIdle) && enable;
        end
    end

    // An AMO swaps its store operand for the ALU result once the old word is read
    always_ff @(posedge clk) begin
        if (state == lsuPkg::StateIdle) begin
            regAddr <= addr;
            regStoreValue <= storeValue;
            if (command == lsuPkg::CmdAtomicMemOp) begin
                regSize <= lsuPkg::SizeWord;
            end else begin
                regSize <= size;
            end
        end else if (state == lsuPkg::StateLoad && !miss &&
                     command == lsuPkg::CmdAtomicMemOp) begin
            oldValue <= loadResult;
            regStoreValue <= atomicResult;
        end
    end

    always_comb begin
        case (state)
            lsuPkg::StateRefill: replacerCommand = lsuPkg::CacheRefill;
            lsuPkg::StateWriteThrough: replacerCommand = lsuPkg::CacheWriteThrough;
            default: replacerCommand = lsuPkg::CacheNone;
        endcase
    end

    // Refill writes take the arrays over, otherwise masked store writes
    always_comb begin
        tagWrite = refillWrite;
        tagWriteValid = refillWrite;
        tagWriteValue = refillTag;
        if (refillWrite) begin
            arrayIndex = refillIndex;
            dataWriteLine = refillData;
            dataWriteMask = '1;
        end else begin
            if (state == lsuPkg::StateIdle) begin
                arrayIndex = addr[offsetWidth +: indexWidth];
            end else begin
                arrayIndex = regAddr[offsetWidth +: indexWidth];
            end
            dataWriteLine = storeLine;
            dataWriteMask = (state == lsuPkg::StateStore && !miss) ? writeMask : '0;
        end
    end

    assert property (@(posedge clk) disable iff (rst) done |-> enable);

    assert property (@(posedge clk) disable iff (rst)
        state == lsuPkg::StateRefill && !replacerDone |=> state == lsuPkg::StateRefill);

    // The ALU result was taken a cycle earlier with this operation
    assert property (@(posedge clk) disable iff (rst)
        state == lsuPkg::StateStore && command == lsuPkg::CmdAtomicMemOp |-> $stable(atomicType));

endmodule

`default_nettype wire

//--- source/lineReplacer.sv
`default_nettype none

module lineReplacer #(
    parameter int addrWidth = 16,
    parameter int lineBytes = 16,
    parameter int indexWidth = 4,
    localparam int offsetWidth = $clog2(lineBytes),
    localparam int tagWidth = addrWidth - indexWidth - offsetWidth,
    localparam int lineAddrWidth = addrWidth - offsetWidth,
    localparam int lineWidth = lineBytes * 8
) (
    input  logic clk,
    input  logic rst,
    input  lsuPkg::cacheCommand replacerCommand,
    input  logic [lineAddrWidth-1:0] lineAddr,
    input  logic [lineWidth-1:0] dataReadLine,
    input  logic memReadGrant,
    input  logic [lineWidth-1:0] memReadValue,
    input  logic memWriteGrant,
    output logic [lineAddrWidth-1:0] memAddr,
    output logic memReadReq,
    output logic memWriteReq,
    output logic [lineWidth-1:0] memWriteValue,
    output logic refillWrite,
    output logic [indexWidth-1:0] refillIndex,
    output logic [tagWidth-1:0] refillTag,
    output logic [lineWidth-1:0] refillData,
    output logic replacerDone
);
    typedef enum logic [2:0] {
        ReplIdle,
        ReplRead,
        ReplCapture,
        ReplWrite,
        ReplDone
    } replacerState;

    replacerState state;
    replacerState nextState;

    // Capture waits a cycle so the array read sees the store just written
    always_comb begin
        nextState = state;
        case (state)
            ReplIdle: begin
                if (replacerCommand == lsuPkg::CacheRefill) begin
                    nextState = ReplRead;
                end else if (replacerCommand == lsuPkg::CacheWriteThrough) begin
                    nextState = ReplCapture;
                end
            end
            ReplRead: begin
                if (memReadGrant) begin
                    nextState = ReplDone;
                end
            end
            ReplCapture: nextState = ReplWrite;
            ReplWrite: begin
                if (memWriteGrant) begin
                    nextState = ReplDone;
                end
            end
            default: nextState = ReplIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ReplIdle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ReplCapture) begin
            memWriteValue <= dataReadLine;
        end
    end

    always_comb begin
        memAddr = lineAddr;
        memReadReq = (state == ReplRead);
        memWriteReq = (state == ReplWrite);
        refillWrite = (state == ReplRead) && memReadGrant;
        refillIndex = lineAddr[indexWidth-1:0];
        refillTag = lineAddr[lineAddrWidth-1:indexWidth];
        refillData = memReadValue;
        replacerDone = (state == ReplDone);
    end

    assert property (@(posedge clk) disable iff (rst) !(memReadReq && memWriteReq));

    // Address comes from the controller and must hold with the request
    assert property (@(posedge clk) disable iff (rst)
        memReadReq && !memReadGrant |=> memReadReq && $stable(memAddr));
    assert property (@(posedge clk) disable iff (rst)
        memWriteReq && !memWriteGrant |=> memWriteReq && $stable(memAddr));

endmodule

`default_nettype wire

//--- source/cacheArrays.sv
`default_nettype none

module cacheArrays #(
    parameter int addrWidth = 16,
    parameter int lineBytes = 16,
    parameter int indexWidth = 4,
    localparam int offsetWidth = $clog2(lineBytes),
    localparam int tagWidth = addrWidth - indexWidth - offsetWidth,
    localparam int lineWidth = lineBytes * 8
) (
    input  logic clk,
    input  logic rst,
    input  logic [indexWidth-1:0] index,
    input  logic tagWrite,
    input  logic tagWriteValid,
    input  logic [tagWidth-1:0] tagWriteValue,
    input  logic [lineWidth-1:0] dataWriteLine,
    input  logic [lineBytes-1:0] dataWriteMask,
    output logic tagReadValid,
    output logic [tagWidth-1:0] tagRead,
    output logic [lineWidth-1:0] dataReadLine
);
    localparam int lineCount = 1 << indexWidth;

    logic [lineCount-1:0] validBits;
    logic [tagWidth-1:0] tagMem [lineCount];
    logic [lineBytes-1:0][7:0] dataMem [lineCount];

    // Valid bits live in flops so reset empties the cache
    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
            tagReadValid <= 1'b0;
        end else begin
            tagReadValid <= validBits[index];
            if (tagWrite) begin
                validBits[index] <= tagWriteValid;
            end
        end
    end

    always_ff @(posedge clk) begin
        tagRead <= tagMem[index];
        if (tagWrite) begin
            tagMem[index] <= tagWriteValue;
        end
    end

    // Read returns the line as it was before this cycle's write
    always_ff @(posedge clk) begin
        dataReadLine <= dataMem[index];
        for (int b = 0; b < lineBytes; b++) begin
            if (dataWriteMask[b]) begin
                dataMem[index][b] <= dataWriteLine[b*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/accessDataPath.sv
`default_nettype none

module accessDataPath #(
    parameter int lineBytes = 16,
    localparam int offsetWidth = $clog2(lineBytes),
    localparam int lineWidth = lineBytes * 8
) (
    input  lsuPkg::accessSize regSize,
    input  logic [offsetWidth-1:0] regOffset,
    input  lsuPkg::atomicOp atomicType,
    input  lsuPkg::word regStoreValue,
    input  logic [lineWidth-1:0] dataReadLine,
    input  lsuPkg::word oldValue,
    output lsuPkg::word loadResult,
    output logic [lineWidth-1:0] storeLine,
    output logic [lineBytes-1:0] writeMask,
    output lsuPkg::word atomicResult
);
    logic [lineWidth-1:0] shiftedLine;
    lsuPkg::word rawWord;
    logic [lineBytes-1:0] sizeMask;

    // Offset counts bytes, so shift by eight times it
    always_comb begin
        shiftedLine = dataReadLine >> {regOffset, 3'b000};
        rawWord = shiftedLine[31:0];
        case (regSize)
            lsuPkg::SizeByte: loadResult = {{24{rawWord[7]}}, rawWord[7:0]};
            lsuPkg::SizeHalfWord: loadResult = {{16{rawWord[15]}}, rawWord[15:0]};
            lsuPkg::SizeUnsignedByte: loadResult = {24'h0, rawWord[7:0]};
            lsuPkg::SizeUnsignedHalfWord: loadResult = {16'h0, rawWord[15:0]};
            default: loadResult = rawWord;
        endcase
    end

    always_comb begin
        case (regSize)
            lsuPkg::SizeByte, lsuPkg::SizeUnsignedByte: begin
                sizeMask = lineBytes'(4'b0001);
            end
            lsuPkg::SizeHalfWord, lsuPkg::SizeUnsignedHalfWord: begin
                sizeMask = lineBytes'(4'b0011);
            end
            default: begin
                sizeMask = lineBytes'(4'b1111);
            end
        endcase
        writeMask = sizeMask << regOffset;
        storeLine = lineWidth'(regStoreValue) << {regOffset, 3'b000};
    end

    // Register value against the old memory word
    always_comb begin
        case (atomicType)
            lsuPkg::AmoAdd: atomicResult = regStoreValue + oldValue;
            lsuPkg::AmoXor: atomicResult = regStoreValue ^ oldValue;
            lsuPkg::AmoAnd: atomicResult = regStoreValue & oldValue;
            lsuPkg::AmoOr: atomicResult = regStoreValue | oldValue;
            lsuPkg::AmoMin: begin
                atomicResult = ($signed(regStoreValue) < $signed(oldValue)) ?
                    regStoreValue : oldValue;
            end
            lsuPkg::AmoMax: begin
                atomicResult = ($signed(regStoreValue) > $signed(oldValue)) ?
                    regStoreValue : oldValue;
            end
            lsuPkg::AmoMinu: atomicResult = (regStoreValue < oldValue) ? regStoreValue : oldValue;
            lsuPkg::AmoMaxu: atomicResult = (regStoreValue > oldValue) ? regStoreValue : oldValue;
            default: atomicResult = regStoreValue;
        endcase
    end

endmodule

`default_nettype wire

//--- source/lsuPkg.sv
`default_nettype none

package lsuPkg;

    typedef logic [31:0] word;

    typedef enum logic [1:0] {
        CmdNone = 2'd0,
        CmdLoad = 2'd1,
        CmdStore = 2'd2,
        CmdAtomicMemOp = 2'd3
    } lsuCommand;

    // Unsigned sizes only matter for loads
    typedef enum logic [2:0] {
        SizeByte = 3'd0,
        SizeHalfWord = 3'd1,
        SizeWord = 3'd2,
        SizeUnsignedByte = 3'd3,
        SizeUnsignedHalfWord = 3'd4
    } accessSize;

    typedef enum logic [3:0] {
        AmoSwap = 4'd0,
        AmoAdd = 4'd1,
        AmoXor = 4'd2,
        AmoAnd = 4'd3,
        AmoOr = 4'd4,
        AmoMin = 4'd5,
        AmoMax = 4'd6,
        AmoMinu = 4'd7,
        AmoMaxu = 4'd8
    } atomicOp;

    typedef enum logic [2:0] {
        StateIdle,
        StateLoad,
        StateStore,
        StateRefill,
        StateWriteThrough
    } lsuState;

    typedef enum logic [1:0] {
        CacheNone,
        CacheRefill,
        CacheWriteThrough
    } cacheCommand;

endpackage

`default_nettype wire
